// ==== compile.f ====
sprite_pkg.sv
video_timing.sv
sprite_rom.sv
rom_arbiter.sv
pacman_sprite.sv
ghost_sprite.sv
video_compositor.sv
sprite_top.sv
tb_sprite.sv

// ==== ghost_sprite.sv ====
module ghost_sprite import sprite_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [8:0]            x_ghost,
  input  logic [8:0]            y_ghost,
  input  logic                  ghost_left,
  input  logic [3:0]            ghost_color,
  input  logic [7:0]            sx,
  input  logic [8:0]            sy,
  input  logic                  pix_stb,
  input  logic                  frame_start,
  input  logic                  grant,
  input  logic                  rd_valid,
  input  logic [ROM_DATA_W-1:0] rd_data,
  output logic                  rom_req,
  output logic [ROM_ADDR_W-1:0] rom_addr,
  output logic [3:0]            pix_idx
);

  logic [8:0] x_q;
  logic [8:0] y_q;
  logic left_q;
  logic [3:0] color_q;
  logic [8:0] dx;
  logic [8:0] dy;
  logic in_box;
  logic [2:0] nib_sel;
  logic [ROM_ADDR_W-1:0] addr_nxt;
  logic [ROM_ADDR_W-1:0] addr_q;
  logic [2:0] nib_q;
  logic pend_q;
  logic [3:0] nib_raw;
  logic [3:0] nib_val;
  logic [3:0] idx_q;

  // Frame latch, color included
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_q     <= '0;
      y_q     <= '0;
      left_q  <= 1'b0;
      color_q <= '0;
    end else if (frame_start) begin
      x_q     <= x_ghost;
      y_q     <= y_ghost;
      left_q  <= ghost_left;
      color_q <= ghost_color;
    end
  end

  // Same widened box test as pacman
  assign dx = {1'b0, sx} - x_q;
  assign dy = sy - y_q;
  assign in_box = ({1'b0, sx} >= x_q) && (dx < 9'(SPRITE_SIZE)) &&
                  (sy >= y_q) && (dy < 9'(SPRITE_SIZE));

  // Single row tile, facing mirrors the nibble
  assign addr_nxt = TILE_GHOST + ROM_ADDR_W'(dy[2:0]);
  assign nib_sel  = left_q ? 3'd7 - dx[2:0] : dx[2:0];

  assign rom_req  = (pix_stb && in_box) || pend_q;
  assign rom_addr = pend_q ? addr_q : addr_nxt;

  // Body nibble takes the ghost color
  assign nib_raw = rd_data[ROM_DATA_W - 4 - 4 * nib_q +: 4];
  assign nib_val = (nib_raw == GHOST_BODY_IDX) ? color_q : nib_raw;

  always_ff @(posedge clk) begin
    if (pix_stb) begin
      addr_q <= addr_nxt;
      nib_q  <= nib_sel;
    end
  end

  // Ghost data usually lands on the next strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q  <= 1'b0;
      idx_q   <= '0;
      pix_idx <= '0;
    end else begin
      pend_q <= rom_req && !grant;
      if (pix_stb) begin
        pix_idx <= rd_valid ? nib_val : idx_q;
        idx_q   <= '0;
      end else if (rd_valid) begin
        idx_q <= nib_val;
      end
    end
  end

endmodule

// ==== pacman_sprite.sv ====
module pacman_sprite import sprite_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [8:0]            x_pac,
  input  logic [8:0]            y_pac,
  input  logic                  h_flip,
  input  logic                  v_flip,
  input  logic [7:0]            sx,
  input  logic [8:0]            sy,
  input  logic                  pix_stb,
  input  logic                  frame_start,
  input  logic                  grant,
  input  logic                  rd_valid,
  input  logic [ROM_DATA_W-1:0] rd_data,
  output logic                  rom_req,
  output logic [ROM_ADDR_W-1:0] rom_addr,
  output logic [3:0]            pix_idx
);

  logic [8:0] x_q;
  logic [8:0] y_q;
  logic h_flip_q;
  logic v_flip_q;
  logic [8:0] dx;
  logic [8:0] dy;
  logic in_box;
  logic mouth_open;
  logic [ROM_ADDR_W-1:0] row_tile;
  logic [ROM_ADDR_W-1:0] col_tile;
  logic [ROM_ADDR_W-1:0] tile_base;
  logic [2:0] row_off;
  logic [2:0] nib_sel;
  logic [ROM_ADDR_W-1:0] addr_nxt;
  logic [ROM_ADDR_W-1:0] addr_q;
  logic [2:0] nib_q;
  logic pend_q;
  logic [3:0] nib_val;
  logic [3:0] idx_q;

  // Position and flips latched once per frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_q      <= '0;
      y_q      <= '0;
      h_flip_q <= 1'b0;
      v_flip_q <= 1'b0;
    end else if (frame_start) begin
      x_q      <= x_pac;
      y_q      <= y_pac;
      h_flip_q <= h_flip;
      v_flip_q <= v_flip;
    end
  end

  ////////////////////////////////////////////////////////////
  // Box test and orientation
  ////////////////////////////////////////////////////////////

  // Offsets in 9 bits with sx widened
  assign dx = {1'b0, sx} - x_q;
  assign dy = sy - y_q;
  assign in_box = ({1'b0, sx} >= x_q) && (dx < 9'(SPRITE_SIZE)) &&
                  (sy >= y_q) && (dy < 9'(SPRITE_SIZE));

  // Mouth frame alternates with position
  assign mouth_open = x_q[1] ^ y_q[1];
  assign row_tile = mouth_open ? TILE_PAC_OPEN_ROW : TILE_PAC_CLOSED_ROW;
  assign col_tile = mouth_open ? TILE_PAC_OPEN_COL : TILE_PAC_CLOSED_COL;

  // Row tiles indexed by dy and column tiles by dx
  always_comb begin
    case ({h_flip_q, v_flip_q})
      2'b11: begin
        tile_base = row_tile;
        row_off   = dy[2:0];
        nib_sel   = dx[2:0];
      end
      2'b01: begin
        tile_base = row_tile;
        row_off   = dy[2:0];
        nib_sel   = 3'd7 - dx[2:0];
      end
      2'b10: begin
        tile_base = col_tile;
        row_off   = dx[2:0];
        nib_sel   = 3'd7 - dy[2:0];
      end
      default: begin
        tile_base = col_tile;
        row_off   = dx[2:0];
        nib_sel   = dy[2:0];
      end
    endcase
  end

  assign addr_nxt = tile_base + ROM_ADDR_W'(row_off);

  ////////////////////////////////////////////////////////////
  // ROM request and return
  ////////////////////////////////////////////////////////////

  // Raised on the strobe and held until granted
  assign rom_req  = (pix_stb && in_box) || pend_q;
  assign rom_addr = pend_q ? addr_q : addr_nxt;

  // Leftmost pixel in the top nibble
  assign nib_val = rd_data[ROM_DATA_W - 4 - 4 * nib_q +: 4];

  // Request context for the pending slot and the data return
  always_ff @(posedge clk) begin
    if (pix_stb) begin
      addr_q <= addr_nxt;
      nib_q  <= nib_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q  <= 1'b0;
      idx_q   <= '0;
      pix_idx <= '0;
    end else begin
      pend_q <= rom_req && !grant;
      if (pix_stb) begin
        // Data landing on the strobe itself is bypassed
        pix_idx <= rd_valid ? nib_val : idx_q;
        idx_q   <= '0;
      end else if (rd_valid) begin
        idx_q <= nib_val;
      end
    end
  end

  // New request only while the raster pixel lies inside the latched box
  a_req_in_box: assert property (@(posedge clk) disable iff (!rst_n)
    (rom_req && !pend_q) |->
      ({1'b0, sx} >= x_q) && ({2'b0, sx} < {1'b0, x_q} + 10'(SPRITE_SIZE)) &&
      (sy >= y_q) && ({1'b0, sy} < {1'b0, y_q} + 10'(SPRITE_SIZE)));

endmodule

// ==== rom_arbiter.sv ====
module rom_arbiter import sprite_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pac_req,
  input  logic [ROM_ADDR_W-1:0] pac_addr,
  input  logic                  ghost_req,
  input  logic [ROM_ADDR_W-1:0] ghost_addr,
  input  logic [ROM_DATA_W-1:0] rom_data,
  output logic                  pac_grant,
  output logic                  ghost_grant,
  output logic                  pac_valid,
  output logic                  ghost_valid,
  output logic [ROM_DATA_W-1:0] rd_data,
  output logic [ROM_ADDR_W-1:0] rom_addr
);

  // Fixed priority with pacman first
  assign pac_grant   = pac_req;
  assign ghost_grant = ghost_req && !pac_req;

  // Granted address goes to the ROM
  assign rom_addr = pac_grant ? pac_addr : ghost_addr;

  // Valid trails the grant by the ROM latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pac_valid   <= 1'b0;
      ghost_valid <= 1'b0;
    end else begin
      pac_valid   <= pac_grant;
      ghost_valid <= ghost_grant;
    end
  end

  // Shared return bus steered by the valids
  assign rd_data = rom_data;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Slot budget lets a waiting ghost in on the next clock
  a_ghost_served: assert property (@(posedge clk) disable iff (!rst_n)
    (ghost_req && !ghost_grant) |=> ghost_grant);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the sprite testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sprite -f compile.f -o sim_sprite > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_sprite > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF '** PASS **' "$sim_log"; then
  exit 0
fi
echo "Pass message not found in $sim_log"
exit 1

// ==== sprite_pkg.sv ====
package sprite_pkg;

  ////////////////////////////////////////////////////////////
  // Raster geometry
  ////////////////////////////////////////////////////////////

  // Horizontal timing in pixels
  localparam int H_ACTIVE     = 256;
  localparam int H_TOTAL      = 320;
  localparam int H_SYNC_START = 272;
  localparam int H_SYNC_LEN   = 24;

  // Vertical timing in lines
  localparam int V_ACTIVE     = 240;
  localparam int V_TOTAL      = 262;
  localparam int V_SYNC_START = 244;
  localparam int V_SYNC_LEN   = 3;

  // Two clocks per pixel, one ROM slot per renderer
  localparam int CLKS_PER_PIX = 2;

  ////////////////////////////////////////////////////////////
  // Sprites and ROM map
  ////////////////////////////////////////////////////////////

  localparam int SPRITE_SIZE = 8;
  localparam int ROM_DEPTH   = 40;
  localparam int ROM_ADDR_W  = 6;
  // 8 nibbles per row, leftmost pixel in the top nibble
  localparam int ROM_DATA_W  = 32;

  // Base row of each tile
  localparam logic [ROM_ADDR_W-1:0] TILE_PAC_OPEN_ROW   = 6'd0;
  localparam logic [ROM_ADDR_W-1:0] TILE_PAC_OPEN_COL   = 6'd8;
  localparam logic [ROM_ADDR_W-1:0] TILE_PAC_CLOSED_ROW = 6'd16;
  localparam logic [ROM_ADDR_W-1:0] TILE_PAC_CLOSED_COL = 6'd24;
  localparam logic [ROM_ADDR_W-1:0] TILE_GHOST          = 6'd32;

  // Palette, entry 0 is transparent
  localparam logic [0:15][11:0] PALETTE = {
    12'h000, 12'hFF0, 12'hF00, 12'hFBF, 12'h0FF, 12'hFB5, 12'hFFF, 12'h22F,
    12'h00A, 12'h0F0, 12'h888, 12'hF80, 12'h8F8, 12'hA0F, 12'h444, 12'hCCC
  };
  localparam logic [11:0] BG_COLOR = 12'h000;

  // Ghost body nibble, recolored per ghost
  localparam logic [3:0] GHOST_BODY_IDX = 4'd2;

endpackage

// ==== sprite_rom.mem ====
// Pacman open mouth, row tile
00111100
01511710
11111100
11110000
11110000
11111100
01111110
00111100
// Pacman open mouth, column tile
00111100
01111110
19111141
11111111
11100111
11700111
01000010
00000000
// Pacman closed, row tile
00111100
01111110
11111111
11111111
11111111
11111111
01111110
00111100
// Pacman closed, column tile
00111100
01111110
11111111
11111111
11111111
11111111
01111110
00111100
// Ghost rows, nibble 2 is the recolored body
00222200
02222220
22672267
22662266
22222222
22222222
22222222
20220220

// ==== sprite_rom.sv ====
module sprite_rom import sprite_pkg::*; (
  input  logic                  clk,
  input  logic [ROM_ADDR_W-1:0] addr,
  output logic [ROM_DATA_W-1:0] data
);

  ////////////////////////////////////////////////////////////
  // Sprite row storage
  ////////////////////////////////////////////////////////////

  // Five tiles of eight rows each
  logic [ROM_DATA_W-1:0] mem [0:ROM_DEPTH-1];

  initial begin
    $readmemh("sprite_rom.mem", mem);
  end

  // One clock read latency
  always_ff @(posedge clk) begin
    data <= mem[addr];
  end

endmodule

// ==== sprite_stim.txt ====
# code x_pac y_pac h_flip v_flip x_ghost y_ghost ghost_left ghost_color probe_x probe_y r g b
# All fields hex, high digit of code is the behavior group, r g b is the expected colour
11 042 020 1 1 0c0 0a0 0 3 44 021 f b 5
12 042 020 0 1 0c0 0a0 0 3 44 021 2 2 f
13 042 020 1 0 0c0 0a0 0 3 44 021 0 f f
14 042 020 0 0 0c0 0a0 0 3 44 021 0 f 0
21 042 020 1 1 0c0 0a0 0 3 48 023 0 0 0
22 040 020 1 1 0c0 0a0 0 3 46 023 f f 0
31 010 010 1 1 080 060 0 3 80 067 f b f
32 010 010 1 1 080 060 1 3 87 067 f b f
33 010 010 1 1 080 060 1 3 80 067 0 0 0
41 042 020 1 1 044 020 0 5 46 022 f f f
42 042 020 1 1 044 020 0 5 44 020 f f 0
43 042 020 1 1 044 020 0 5 48 027 0 0 0
51 040 020 1 1 0c0 0a0 0 3 3f 023 0 0 0
52 040 020 1 1 0c0 0a0 0 3 48 023 0 0 0
53 040 020 1 1 0c0 0a0 0 3 43 01f 0 0 0
54 040 020 1 1 0c0 0a0 0 3 43 028 0 0 0
55 17f 061 1 1 080 060 0 3 7f 064 0 0 0
56 17f 061 1 1 080 060 0 3 88 064 0 0 0
57 17f 061 1 1 080 060 0 3 82 05f 0 0 0
58 17f 061 1 1 080 060 0 3 82 068 0 0 0

// ==== sprite_top.sv ====
module sprite_top import sprite_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [8:0] x_pac,
  input  logic [8:0] y_pac,
  input  logic       h_flip,
  input  logic       v_flip,
  input  logic [8:0] x_ghost,
  input  logic [8:0] y_ghost,
  input  logic       ghost_left,
  input  logic [3:0] ghost_color,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b,
  output logic [7:0] out_x,
  output logic [8:0] out_y,
  output logic       out_de,
  output logic       hsync,
  output logic       vsync
);

  // Raster
  logic [7:0] sx;
  logic [8:0] sy;
  logic pix_stb;
  logic de;
  logic frame_start;

  // ROM sharing
  logic pac_req;
  logic ghost_req;
  logic [ROM_ADDR_W-1:0] pac_addr;
  logic [ROM_ADDR_W-1:0] ghost_addr;
  logic pac_grant;
  logic ghost_grant;
  logic pac_valid;
  logic ghost_valid;
  logic [ROM_DATA_W-1:0] rd_data;
  logic [ROM_ADDR_W-1:0] rom_addr;
  logic [ROM_DATA_W-1:0] rom_data;

  // Layer indices
  logic [3:0] pac_idx;
  logic [3:0] ghost_idx;

  video_timing u_timing (
    .clk(clk), .rst_n(rst_n), .sx(sx), .sy(sy), .pix_stb(pix_stb),
    .de(de), .hsync(hsync), .vsync(vsync), .frame_start(frame_start)
  );

  pacman_sprite u_pacman (
    .clk(clk), .rst_n(rst_n), .x_pac(x_pac), .y_pac(y_pac),
    .h_flip(h_flip), .v_flip(v_flip), .sx(sx), .sy(sy),
    .pix_stb(pix_stb), .frame_start(frame_start), .grant(pac_grant),
    .rd_valid(pac_valid), .rd_data(rd_data), .rom_req(pac_req),
    .rom_addr(pac_addr), .pix_idx(pac_idx)
  );

  ghost_sprite u_ghost (
    .clk(clk), .rst_n(rst_n), .x_ghost(x_ghost), .y_ghost(y_ghost),
    .ghost_left(ghost_left), .ghost_color(ghost_color), .sx(sx), .sy(sy),
    .pix_stb(pix_stb), .frame_start(frame_start), .grant(ghost_grant),
    .rd_valid(ghost_valid), .rd_data(rd_data), .rom_req(ghost_req),
    .rom_addr(ghost_addr), .pix_idx(ghost_idx)
  );

  rom_arbiter u_arbiter (
    .clk(clk), .rst_n(rst_n), .pac_req(pac_req), .pac_addr(pac_addr),
    .ghost_req(ghost_req), .ghost_addr(ghost_addr), .rom_data(rom_data),
    .pac_grant(pac_grant), .ghost_grant(ghost_grant), .pac_valid(pac_valid),
    .ghost_valid(ghost_valid), .rd_data(rd_data), .rom_addr(rom_addr)
  );

  sprite_rom u_rom (
    .clk(clk), .addr(rom_addr), .data(rom_data)
  );

  video_compositor u_compositor (
    .clk(clk), .rst_n(rst_n), .pix_stb(pix_stb), .sx(sx), .sy(sy), .de(de),
    .pac_idx(pac_idx), .ghost_idx(ghost_idx), .r(r), .g(g), .b(b),
    .out_x(out_x), .out_y(out_y), .out_de(out_de)
  );

endmodule

// ==== tb_sprite.sv ====
module tb_sprite import sprite_pkg::*; ();

  logic       clk;
  logic       rst_n;
  logic [8:0] x_pac;
  logic [8:0] y_pac;
  logic       h_flip;
  logic       v_flip;
  logic [8:0] x_ghost;
  logic [8:0] y_ghost;
  logic       ghost_left;
  logic [3:0] ghost_color;
  logic [3:0] r;
  logic [3:0] g;
  logic [3:0] b;
  logic [7:0] out_x;
  logic [8:0] out_y;
  logic       out_de;
  logic       hsync;
  logic       vsync;

  // Test bookkeeping
  string  stim_lines[$];
  int     tests_run;
  int     tests_failed;
  longint cycle_count;
  longint cycle_limit;

  // Raster monitor over one frame between two vsync rises
  int   mon_state;
  int   hs_count;
  int   vs_lines;
  int   de_lines;
  int   de_clks;
  int   short_lines;
  logic last_vs;
  logic last_hs;
  logic last_de;

  sprite_top UUT (
    .clk(clk), .rst_n(rst_n), .x_pac(x_pac), .y_pac(y_pac), .h_flip(h_flip),
    .v_flip(v_flip), .x_ghost(x_ghost), .y_ghost(y_ghost), .ghost_left(ghost_left),
    .ghost_color(ghost_color), .r(r), .g(g), .b(b), .out_x(out_x), .out_y(out_y),
    .out_de(out_de), .hsync(hsync), .vsync(vsync)
  );

  always #20 clk = ~clk;

  // Run limit in clocks armed once the test count is known
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Raster monitor
  ////////////////////////////////////////////////////////////

  // Sampled mid-cycle while outputs are settled
  always @(negedge clk) begin
    if (!rst_n) begin
      mon_state   = 0;
      hs_count    = 0;
      vs_lines    = 0;
      de_lines    = 0;
      de_clks     = 0;
      short_lines = 0;
      last_vs     = 1'b0;
      last_hs     = 1'b0;
      last_de     = 1'b0;
    end else begin
      case (mon_state)
        0: begin
          if (vsync && !last_vs) begin
            mon_state = 1;
          end
        end
        1: begin
          if (vsync && !last_vs) begin
            mon_state = 2;
          end else begin
            if (hsync && !last_hs) begin
              hs_count = hs_count + 1;
              // Lines inside the vsync pulse
              if (vsync) begin
                vs_lines = vs_lines + 1;
              end
            end
            if (out_de) begin
              de_clks = de_clks + 1;
            end
            if (out_de && !last_de) begin
              de_lines = de_lines + 1;
            end
            // Each pixel holds out_de for CLKS_PER_PIX clocks
            if (!out_de && last_de) begin
              if (de_clks != H_ACTIVE * CLKS_PER_PIX) begin
                short_lines = short_lines + 1;
              end
              de_clks = 0;
            end
          end
        end
        default: begin
        end
      endcase
      last_vs = vsync;
      last_hs = hsync;
      last_de = out_de;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic string group_name(input logic [3:0] grp);
    case (grp)
      4'h1: return "orientation";
      4'h2: return "mouth frame";
      4'h3: return "ghost";
      4'h4: return "layering";
      4'h5: return "outside box";
      default: return "other";
    endcase
  endfunction

  // Keeps lines whose first field is a number
  task automatic read_stimulus();
    int         fd;
    int         fields;
    string      line;
    logic [7:0] first;
    fd = $fopen("sprite_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open sprite_stim.txt for reading");
    end else begin
      while ($fgets(line, fd) != 0) begin
        fields = $sscanf(line, "%h", first);
        if (fields > 0) begin
          stim_lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  // Frame boundary where vsync sits in vertical blanking
  task automatic wait_vsync_rise();
    logic last;
    last = 1'b1;
    @(negedge clk);
    while (!(vsync && !last)) begin
      last = vsync;
      @(negedge clk);
    end
  endtask

  // Output carries its own coordinates so match on out_x and out_y
  task automatic wait_for_probe(input logic [7:0] px, input logic [8:0] py);
    @(negedge clk);
    while (!(out_de && out_x == px && out_y == py)) begin
      @(negedge clk);
    end
  endtask

  task automatic run_probe_test(input string line);
    int         fields;
    logic       bad;
    logic [7:0] code;
    logic [8:0] xp;
    logic [8:0] yp;
    logic       hf;
    logic       vf;
    logic [8:0] xg;
    logic [8:0] yg;
    logic       gl;
    logic [3:0] gc;
    logic [7:0] px;
    logic [8:0] py;
    logic [3:0] er;
    logic [3:0] eg;
    logic [3:0] eb;
    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     code, xp, yp, hf, vf, xg, yg, gl, gc, px, py, er, eg, eb);
    bad = 1'b0;
    tests_run = tests_run + 1;
    if (fields != 14) begin
      $display("Stimulus line has %0d fields instead of 14: %s", fields, line);
      tests_failed = tests_failed + 1;
    end else begin
      // New inputs taken at the next frame start
      @(negedge clk);
      x_pac       = xp;
      y_pac       = yp;
      h_flip      = hf;
      v_flip      = vf;
      x_ghost     = xg;
      y_ghost     = yg;
      ghost_left  = gl;
      ghost_color = gc;
      wait_vsync_rise();
      wait_for_probe(px, py);
      if (r !== er) begin
        $display("ERROR test %h: r expected 0x%h got 0x%h", code, er, r);
        bad = 1'b1;
      end
      if (g !== eg) begin
        $display("ERROR test %h: g expected 0x%h got 0x%h", code, eg, g);
        bad = 1'b1;
      end
      if (b !== eb) begin
        $display("ERROR test %h: b expected 0x%h got 0x%h", code, eb, b);
        bad = 1'b1;
      end
      if (bad) begin
        tests_failed = tests_failed + 1;
        $display("test %h %s at (%h,%h): mismatch", code, group_name(code[7:4]), px, py);
      end else begin
        $display("test %h %s at (%h,%h): ok", code, group_name(code[7:4]), px, py);
      end
    end
  endtask

  task automatic check_raster();
    logic bad;
    bad = 1'b0;
    tests_run = tests_run + 1;
    if (mon_state != 2) begin
      $display("Raster monitor never saw a whole frame between two vsync pulses");
      bad = 1'b1;
    end else begin
      if (hs_count != V_TOTAL) begin
        $display("ERROR raster: hsync pulses expected 0x%h got 0x%h", V_TOTAL, hs_count);
        bad = 1'b1;
      end
      if (vs_lines != V_SYNC_LEN) begin
        $display("ERROR raster: vsync lines expected 0x%h got 0x%h", V_SYNC_LEN, vs_lines);
        bad = 1'b1;
      end
      if (de_lines != V_ACTIVE) begin
        $display("ERROR raster: out_de lines expected 0x%h got 0x%h", V_ACTIVE, de_lines);
        bad = 1'b1;
      end
      if (short_lines != 0) begin
        $display("%0d active lines did not carry %0d out_de pixels", short_lines, H_ACTIVE);
        bad = 1'b1;
      end
    end
    if (bad) begin
      tests_failed = tests_failed + 1;
      $display("test raster timing: mismatch");
    end else begin
      $display("test raster timing: ok");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    x_pac        = '0;
    y_pac        = '0;
    h_flip       = 1'b0;
    v_flip       = 1'b0;
    x_ghost      = '0;
    y_ghost      = '0;
    ghost_left   = 1'b0;
    ghost_color  = '0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_count  = 0;
    cycle_limit  = 0;
    read_stimulus();
    // About one frame per probe plus slack for reset and the first frame
    cycle_limit = longint'(stim_lines.size() + 2) * V_TOTAL * H_TOTAL * CLKS_PER_PIX;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (stim_lines.size() == 0) begin
      $display("No test lines were read from sprite_stim.txt");
      tests_failed = tests_failed + 1;
    end else begin
      foreach (stim_lines[i]) begin
        run_probe_test(stim_lines[i]);
      end
      check_raster();
    end
    $display("Summary: %0d tests, %0d passed, %0d failed",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== video_compositor.sv ====
module video_compositor import sprite_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pix_stb,
  input  logic [7:0] sx,
  input  logic [8:0] sy,
  input  logic       de,
  input  logic [3:0] pac_idx,
  input  logic [3:0] ghost_idx,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b,
  output logic [7:0] out_x,
  output logic [8:0] out_y,
  output logic       out_de
);

  logic [7:0] x_d1;
  logic [7:0] x_d2;
  logic [8:0] y_d1;
  logic [8:0] y_d2;
  logic de_d1;
  logic de_d2;
  logic [3:0] sel_idx;
  logic [11:0] color;

  // Ghost on top, index 0 lets the layer below through
  assign sel_idx = (ghost_idx != 4'd0) ? ghost_idx : pac_idx;
  assign color   = (sel_idx == 4'd0) ? BG_COLOR : PALETTE[sel_idx];

  // Control delay line and colour output
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      de_d1  <= 1'b0;
      de_d2  <= 1'b0;
      out_de <= 1'b0;
      r      <= '0;
      g      <= '0;
      b      <= '0;
    end else if (pix_stb) begin
      de_d1  <= de;
      de_d2  <= de_d1;
      out_de <= de_d2;
      // Blanking forces black
      {r, g, b} <= de_d2 ? color : 12'h000;
    end
  end

  // Coordinates follow the colour
  always_ff @(posedge clk) begin
    if (pix_stb) begin
      x_d1  <= sx;
      y_d1  <= sy;
      x_d2  <= x_d1;
      y_d2  <= y_d1;
      out_x <= x_d2;
      out_y <= y_d2;
    end
  end

endmodule

// ==== video_timing.sv ====
module video_timing import sprite_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  output logic [7:0] sx,
  output logic [8:0] sy,
  output logic       pix_stb,
  output logic       de,
  output logic       hsync,
  output logic       vsync,
  output logic       frame_start
);

  logic [$clog2(CLKS_PER_PIX)-1:0] div_cnt;
  logic [8:0] h_cnt;
  logic [8:0] v_cnt;
  logic [8:0] h_nxt;
  logic [8:0] v_nxt;

  // Clock divider for the pixel strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (pix_stb) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign pix_stb = (div_cnt == CLKS_PER_PIX - 1);

  // Next raster position, wraps at the totals
  always_comb begin
    h_nxt = h_cnt + 9'd1;
    v_nxt = v_cnt;
    if (h_cnt == 9'(H_TOTAL - 1)) begin
      h_nxt = '0;
      if (v_cnt == 9'(V_TOTAL - 1)) begin
        v_nxt = '0;
      end else begin
        v_nxt = v_cnt + 9'd1;
      end
    end
  end

  // Counters and decodes move together on the strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt       <= '0;
      v_cnt       <= '0;
      de          <= 1'b0;
      hsync       <= 1'b0;
      vsync       <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      if (pix_stb) begin
        h_cnt <= h_nxt;
        v_cnt <= v_nxt;
        de    <= (h_nxt < 9'(H_ACTIVE)) && (v_nxt < 9'(V_ACTIVE));
        hsync <= (h_nxt >= 9'(H_SYNC_START)) && (h_nxt < 9'(H_SYNC_START + H_SYNC_LEN));
        vsync <= (v_nxt >= 9'(V_SYNC_START)) && (v_nxt < 9'(V_SYNC_START + V_SYNC_LEN));
        // One clock pulse while the raster sits on pixel 0,0
        frame_start <= (h_nxt == '0) && (v_nxt == '0);
      end
    end
  end

  assign sx = h_cnt[7:0];
  assign sy = v_cnt;

endmodule
